//--- hw/tlb_params.svh
// tlb sizing macros
// entry count, address widths and result queue depth for the translation slice

`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

// ==================================================
// tlb array
// ==================================================
`define TLB_ENTRY_NUM 16
`define TLB_IDX_W     4

// address widths
`define TLB_VALEN     32
`define TLB_PALEN     32
`define TLB_ASID_W    10

// ==================================================
// result queue
// ==================================================
`define XQ_DEPTH      4
`define XQ_PTR_W      2

`endif

//--- hw/tlb_pkg.sv
// tlb types
// entry, search, maintenance and translation result structs plus the
// access, invtlb and exception encodings

`include "tlb_params.svh"

package tlb_pkg;

  // ==================================================
  // encodings
  // ==================================================
  typedef enum logic [1:0] {
    ACC_LOAD  = 2'd0,
    ACC_STORE = 2'd1,
    ACC_FETCH = 2'd2
  } acc_op_e;

  // invtlb op field, codes 0 to 6
  typedef enum logic [2:0] {
    INV_ALL0         = 3'd0,
    INV_ALL1         = 3'd1,
    INV_GLO          = 3'd2,
    INV_NGLO         = 3'd3,
    INV_NGLO_ASID    = 3'd4,
    INV_NGLO_ASID_VA = 3'd5,
    INV_ASID_VA      = 3'd6
  } inv_op_e;

  typedef enum logic [2:0] {
    XEXC_NONE   = 3'd0,
    XEXC_REFILL = 3'd1,
    XEXC_PIL    = 3'd2,
    XEXC_PIS    = 3'd3,
    XEXC_PIF    = 3'd4,
    XEXC_PPI    = 3'd5,
    XEXC_PME    = 3'd6
  } xlate_exc_e;

  // ==================================================
  // structs
  // ==================================================
  // one half of the even/odd pair, ppn holds pa[31:12]
  typedef struct packed {
    logic [19:0] ppn;
    logic [1:0]  plv;
    logic [1:0]  mat;
    logic        dirty;
    logic        valid;
  } tlb_page_t;

  typedef struct packed {
    logic                    exist;
    logic [`TLB_VALEN-1:13]  vppn;
    logic [5:0]              page_size;
    logic                    glo;
    logic [`TLB_ASID_W-1:0]  asid;
    tlb_page_t               even;
    tlb_page_t               odd;
  } tlb_entry_t;

  typedef struct packed {
    logic [`TLB_VALEN-1:0]   vaddr;
    logic [`TLB_ASID_W-1:0]  asid;
    acc_op_e                 acc;
    logic [1:0]              cur_plv;
  } tlb_search_req_t;

  // registered search result, request carried along for the check stage
  typedef struct packed {
    logic                    found;
    logic [`TLB_IDX_W-1:0]   idx;
    logic [5:0]              page_size;
    tlb_page_t               page;
    tlb_search_req_t         req;
  } tlb_search_rsp_t;

  typedef struct packed {
    logic [`TLB_IDX_W-1:0]   idx;
    tlb_entry_t              entry;
  } tlb_write_req_t;

  typedef struct packed {
    inv_op_e                 op;
    logic [`TLB_ASID_W-1:0]  asid;
    logic [`TLB_VALEN-1:13]  vppn;
  } tlb_inv_req_t;

  typedef struct packed {
    logic [`TLB_PALEN-1:0]   paddr;
    logic [1:0]              mat;
    xlate_exc_e              exc;
    logic [`TLB_IDX_W-1:0]   idx;
  } xlate_result_t;

endpackage

//--- hw/tlb_array.sv
// tlb entry array
// fully associative search with even/odd page select, indexed read (tlbrd),
// indexed write (tlbwr/tlbfill) and invtlb invalidation

`timescale 1ns/1ps
`include "tlb_params.svh"

module tlb_array (
  input  logic                     clk,
  input  logic                     rst_n,
  // search
  input  logic                     search_valid,
  input  tlb_pkg::tlb_search_req_t search_req,
  output logic                     rsp_push,
  output tlb_pkg::tlb_search_rsp_t search_rsp,
  // tlbrd
  input  logic                     read_valid,
  input  logic [`TLB_IDX_W-1:0]    read_idx,
  output tlb_pkg::tlb_entry_t      read_entry,
  // tlbwr / tlbfill
  input  logic                     write_valid,
  input  tlb_pkg::tlb_write_req_t  write_req,
  // invtlb
  input  logic                     inv_valid,
  input  tlb_pkg::tlb_inv_req_t    inv_req
);
  import tlb_pkg::*;

  // entry payload, existence kept apart so reset only touches one bit each
  tlb_entry_t                entries [`TLB_ENTRY_NUM];
  logic [`TLB_ENTRY_NUM-1:0] entry_exist;

  logic [`TLB_ENTRY_NUM-1:0] hit;
  tlb_entry_t                hit_entry;
  logic [`TLB_IDX_W-1:0]     hit_idx;
  logic                      hit_odd;
  tlb_page_t                 hit_page;

  logic [`TLB_ENTRY_NUM-1:0] inv_asid_eq;
  logic [`TLB_ENTRY_NUM-1:0] inv_va_eq;
  logic [`TLB_ENTRY_NUM-1:0] inv_hit;

  tlb_entry_t                rd_entry;

  // vppn compare, 4 MB pages ignore va[21:13]
  function automatic logic va_match(input tlb_entry_t e,
                                    input logic [`TLB_VALEN-1:13] va);
    logic small_page;
    small_page = (e.page_size == 6'd12);
    if (small_page) begin
      return e.vppn == va;
    end
    return e.vppn[`TLB_VALEN-1:22] == va[`TLB_VALEN-1:22];
  endfunction

  // ==================================================
  // search
  // ==================================================
  // matches are unique, so the hit entry and index are plain ORs
  always_comb begin
    hit_entry = '0;
    hit_idx   = '0;
    for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
      hit[i] = entry_exist[i] &&
               (entries[i].glo || (entries[i].asid == search_req.asid)) &&
               va_match(entries[i], search_req.vaddr[`TLB_VALEN-1:13]);
      if (hit[i]) begin
        hit_entry = hit_entry | entries[i];
        hit_idx   = hit_idx | `TLB_IDX_W'(i);
      end
    end
    // parity bit is the lowest vppn bit the page size leaves over
    hit_odd  = (hit_entry.page_size == 6'd12) ? search_req.vaddr[12] : search_req.vaddr[21];
    hit_page = hit_odd ? hit_entry.odd : hit_entry.even;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_push <= 1'b0;
    end else begin
      rsp_push <= search_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (search_valid) begin
      search_rsp.found     <= |hit;
      search_rsp.idx       <= hit_idx;
      search_rsp.page_size <= hit_entry.page_size;
      search_rsp.page      <= hit_page;
      search_rsp.req       <= search_req;
    end
  end

  // ==================================================
  // invtlb select
  // ==================================================
  always_comb begin
    for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
      inv_asid_eq[i] = (entries[i].asid == inv_req.asid);
      inv_va_eq[i]   = va_match(entries[i], inv_req.vppn);
      case (inv_req.op)
        INV_ALL0,
        INV_ALL1:         inv_hit[i] = 1'b1;
        INV_GLO:          inv_hit[i] = entries[i].glo;
        INV_NGLO:         inv_hit[i] = !entries[i].glo;
        INV_NGLO_ASID:    inv_hit[i] = !entries[i].glo && inv_asid_eq[i];
        INV_NGLO_ASID_VA: inv_hit[i] = !entries[i].glo && inv_asid_eq[i] && inv_va_eq[i];
        INV_ASID_VA:      inv_hit[i] = (entries[i].glo || inv_asid_eq[i]) && inv_va_eq[i];
        default:          inv_hit[i] = 1'b0;
      endcase
    end
  end

  // ==================================================
  // maintenance
  // ==================================================
  // write wins over invalidate in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      entry_exist <= '0;
    end else if (write_valid) begin
      entry_exist[write_req.idx] <= write_req.entry.exist;
    end else if (inv_valid) begin
      entry_exist <= entry_exist & ~inv_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (write_valid) begin
      entries[write_req.idx] <= write_req.entry;
    end
  end

  // tlbrd returns the live exist bit with the stored payload
  always_comb begin
    rd_entry       = entries[read_idx];
    rd_entry.exist = entry_exist[read_idx];
  end

  always_ff @(posedge clk) begin
    if (read_valid) begin
      read_entry <= rd_entry;
    end
  end

endmodule

//--- hw/xlate_fifo.sv
// search result queue
// circular buffer between the tlb array and the check stage, room
// is raised early to cover the search already in flight

`timescale 1ns/1ps
`include "tlb_params.svh"

module xlate_fifo (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     push,
  input  tlb_pkg::tlb_search_rsp_t push_data,
  input  logic                     pop,
  output tlb_pkg::tlb_search_rsp_t head,
  output logic                     not_empty,
  output logic                     room
);
  import tlb_pkg::*;

  // one slot kept back for the search accepted this cycle
  localparam int unsigned ROOM_MAX = `XQ_DEPTH - 2;

  tlb_search_rsp_t      mem [`XQ_DEPTH];
  logic [`XQ_PTR_W-1:0] wr_ptr;
  logic [`XQ_PTR_W-1:0] rd_ptr;
  logic [`XQ_PTR_W:0]   count;

  function automatic logic [`XQ_PTR_W-1:0] ptr_inc(input logic [`XQ_PTR_W-1:0] p);
    if (p == `XQ_PTR_W'(`XQ_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign room      = (32'(count) <= ROOM_MAX);

endmodule

//--- hw/xlate_check.sv
// translation check stage
// pops one queued search result, forms the physical address and
// classifies the exception, result registered for one cycle

`timescale 1ns/1ps
`include "tlb_params.svh"

module xlate_check (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     avail,
  input  logic                     stall,
  input  tlb_pkg::tlb_search_rsp_t head,
  output logic                     pop,
  output logic                     xlate_valid,
  output tlb_pkg::xlate_result_t   xlate_result
);
  import tlb_pkg::*;

  logic                  small_page;
  logic [`TLB_PALEN-1:0] paddr_nxt;
  logic [1:0]            mat_nxt;
  xlate_exc_e            exc_nxt;

  assign pop = avail && !stall;

  // ==================================================
  // address formation
  // ==================================================
  // a miss leaves paddr and mat at zero
  always_comb begin
    small_page = (head.page_size == 6'd12);
    if (!head.found) begin
      paddr_nxt = '0;
      mat_nxt   = '0;
    end else begin
      mat_nxt = head.page.mat;
      if (small_page) begin
        paddr_nxt = {head.page.ppn, head.req.vaddr[11:0]};
      end else begin
        paddr_nxt = {head.page.ppn[19:9], head.req.vaddr[20:0]};
      end
    end
  end

  // ==================================================
  // exception priority
  // ==================================================
  always_comb begin
    if (!head.found) begin
      exc_nxt = XEXC_REFILL;
    end else if (!head.page.valid) begin
      case (head.req.acc)
        ACC_STORE: exc_nxt = XEXC_PIS;
        ACC_FETCH: exc_nxt = XEXC_PIF;
        default:   exc_nxt = XEXC_PIL;
      endcase
    end else if (head.req.cur_plv > head.page.plv) begin
      exc_nxt = XEXC_PPI;
    end else if ((head.req.acc == ACC_STORE) && !head.page.dirty) begin
      // first store to a clean page
      exc_nxt = XEXC_PME;
    end else begin
      exc_nxt = XEXC_NONE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      xlate_valid <= 1'b0;
    end else begin
      xlate_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      xlate_result.paddr <= paddr_nxt;
      xlate_result.mat   <= mat_nxt;
      xlate_result.exc   <= exc_nxt;
      xlate_result.idx   <= head.idx;
    end
  end

endmodule

//--- hw/mmu_xlate_top.sv
// address translation slice
// tlb array feeding a result queue feeding the check stage,
// maintenance ports go straight to the array

`timescale 1ns/1ps
`include "tlb_params.svh"

module mmu_xlate_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // search path
  input  logic                     search_valid,
  input  tlb_pkg::tlb_search_req_t search_req,
  output logic                     search_room,
  input  logic                     stall,
  output logic                     xlate_valid,
  output tlb_pkg::xlate_result_t   xlate_result,
  // maintenance
  input  logic                     read_valid,
  input  logic [`TLB_IDX_W-1:0]    read_idx,
  output tlb_pkg::tlb_entry_t      read_entry,
  input  logic                     write_valid,
  input  tlb_pkg::tlb_write_req_t  write_req,
  input  logic                     inv_valid,
  input  tlb_pkg::tlb_inv_req_t    inv_req
);
  import tlb_pkg::*;

  logic            rsp_push;
  tlb_search_rsp_t search_rsp;
  tlb_search_rsp_t q_head;
  logic            q_not_empty;
  logic            q_pop;

  tlb_array tlb_array_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .search_valid (search_valid),
    .search_req   (search_req),
    .rsp_push     (rsp_push),
    .search_rsp   (search_rsp),
    .read_valid   (read_valid),
    .read_idx     (read_idx),
    .read_entry   (read_entry),
    .write_valid  (write_valid),
    .write_req    (write_req),
    .inv_valid    (inv_valid),
    .inv_req      (inv_req)
  );

  xlate_fifo xlate_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (rsp_push),
    .push_data (search_rsp),
    .pop       (q_pop),
    .head      (q_head),
    .not_empty (q_not_empty),
    .room      (search_room)
  );

  xlate_check xlate_check_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .avail        (q_not_empty),
    .stall        (stall),
    .head         (q_head),
    .pop          (q_pop),
    .xlate_valid  (xlate_valid),
    .xlate_result (xlate_result)
  );

endmodule

//--- verif/mmu_xlate_asserts.sv
// result queue and check stage assertions
// bound into the queue for push/pop safety and into the top for stall

`timescale 1ns/1ps
`include "tlb_params.svh"

module mmu_xlate_asserts (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 q_push,
  input logic                 q_pop,
  input logic [`XQ_PTR_W:0]   q_count,
  input logic                 stall,
  input logic                 xlate_valid
);

  // ==================================================
  // queue
  // ==================================================
  push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(q_push && q_count == (`XQ_PTR_W+1)'(`XQ_DEPTH)))
    else $error("push into a full result queue");

  pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !(q_pop && q_count == '0))
    else $error("pop from an empty result queue");

  // ==================================================
  // check stage
  // ==================================================
  // a stalled cycle pops nothing, so no result follows it
  no_valid_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> !xlate_valid)
    else $error("xlate_valid raised after a stalled cycle");

endmodule

bind xlate_fifo mmu_xlate_asserts fifo_sva_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .q_push      (push),
  .q_pop       (pop),
  .q_count     (count),
  .stall       (1'b0),
  .xlate_valid (1'b0)
);

bind mmu_xlate_top mmu_xlate_asserts top_sva_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .q_push      (1'b0),
  .q_pop       (1'b0),
  .q_count     ({(`XQ_PTR_W+1){1'b0}}),
  .stall       (stall),
  .xlate_valid (xlate_valid)
);

//--- verif/mmu_xlate_tb.sv
// translation slice testbench
// mirror of the tlb entries, reference translation, in-order scoreboard
// and stall stress of the result queue

`timescale 1ns/1ps
`include "tlb_params.svh"

module mmu_xlate_tb;
  import tlb_pkg::*;

  logic            clk;
  logic            rst_n;
  logic            search_valid;
  tlb_search_req_t search_req;
  logic            search_room;
  logic            stall;
  logic            xlate_valid;
  xlate_result_t   xlate_result;
  logic            read_valid;
  logic [`TLB_IDX_W-1:0] read_idx;
  tlb_entry_t      read_entry;
  logic            write_valid;
  tlb_write_req_t  write_req;
  logic            inv_valid;
  tlb_inv_req_t    inv_req;

  integer          seed;
  int              error_count;
  tlb_entry_t      mirror [`TLB_ENTRY_NUM];
  xlate_result_t   exp_q [$];

  mmu_xlate_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .search_valid (search_valid),
    .search_req   (search_req),
    .search_room  (search_room),
    .stall        (stall),
    .xlate_valid  (xlate_valid),
    .xlate_result (xlate_result),
    .read_valid   (read_valid),
    .read_idx     (read_idx),
    .read_entry   (read_entry),
    .write_valid  (write_valid),
    .write_req    (write_req),
    .inv_valid    (inv_valid),
    .inv_req      (inv_req)
  );

  always #10 clk = ~clk;

  // ==================================================
  // checking
  // ==================================================
  task automatic fail_stop();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
      fail_stop();
    end
  endtask

  // page size in bits, both compares ignore everything below the pair
  function automatic logic va_hits(input tlb_entry_t e, input logic [31:0] va);
    int ps;
    ps = e.page_size;
    return ((va ^ {e.vppn, 13'h0}) >> (ps + 1)) == 32'h0;
  endfunction

  function automatic xlate_result_t ref_translate(input tlb_search_req_t req);
    xlate_result_t res;
    tlb_page_t     pg;
    logic [31:0]   mask;
    logic          hit;
    int            ps;
    res = '0;
    pg  = '0;
    hit = 1'b0;
    for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
      if (mirror[i].exist && (mirror[i].glo || mirror[i].asid == req.asid) &&
          va_hits(mirror[i], req.vaddr)) begin
        hit       = 1'b1;
        ps        = mirror[i].page_size;
        res.idx   = `TLB_IDX_W'(i);
        pg        = req.vaddr[ps] ? mirror[i].odd : mirror[i].even;
        mask      = (32'd1 << ps) - 32'd1;
        res.paddr = ({pg.ppn, 12'h0} & ~mask) | (req.vaddr & mask);
        res.mat   = pg.mat;
      end
    end
    if (!hit) begin
      res.exc = XEXC_REFILL;
    end else if (!pg.valid) begin
      res.exc = (req.acc == ACC_STORE) ? XEXC_PIS :
                (req.acc == ACC_FETCH) ? XEXC_PIF : XEXC_PIL;
    end else if (req.cur_plv > pg.plv) begin
      res.exc = XEXC_PPI;
    end else if (req.acc == ACC_STORE && !pg.dirty) begin
      res.exc = XEXC_PME;
    end else begin
      res.exc = XEXC_NONE;
    end
    return res;
  endfunction

  // scoreboard, results must come back in request order
  always @(negedge clk) begin
    if (rst_n && xlate_valid) begin
      if (exp_q.size() == 0) begin
        $display("a translation result arrived with no search outstanding");
        fail_stop();
      end else begin
        check_value(xlate_result, exp_q.pop_front(), "xlate result");
      end
    end
  end

  // ==================================================
  // stimulus helpers
  // ==================================================
  function automatic tlb_page_t rand_page();
    tlb_page_t   pg;
    logic [31:0] r;
    r        = $random(seed);
    pg.ppn   = r[19:0];
    pg.plv   = r[21:20];
    pg.mat   = r[23:22];
    pg.dirty = r[24];
    pg.valid = (r[27:25] != 3'd0);
    return pg;
  endfunction

  // index sits in vppn[25:22] and the low asid bits, so no two entries overlap
  function automatic tlb_entry_t rand_entry(input int i);
    tlb_entry_t  e;
    logic [31:0] r;
    r           = $random(seed);
    e.exist     = 1'b1;
    e.vppn      = {r[5:0], 4'(i), r[14:6]};
    e.page_size = r[15] ? 6'd21 : 6'd12;
    e.glo       = (r[17:16] == 2'd0);
    e.asid      = {r[23:18], 4'(i)};
    e.even      = rand_page();
    e.odd       = rand_page();
    return e;
  endfunction

  function automatic tlb_search_req_t rand_search();
    tlb_search_req_t req;
    logic [31:0]     r;
    logic [31:0]     r2;
    r   = $random(seed);
    r2  = $random(seed);
    req.vaddr   = {mirror[r[3:0]].vppn, r[16:4]};
    req.asid    = mirror[r[3:0]].asid;
    req.cur_plv = r2[13:12];
    // a few wild addresses and foreign asids for refill
    if (r[19:17] == 3'd0) begin
      req.vaddr = r2;
    end
    if (r[22:20] == 3'd0) begin
      req.asid = r2[25:16];
    end
    case (r2[1:0])
      2'd1:    req.acc = ACC_STORE;
      2'd2:    req.acc = ACC_FETCH;
      default: req.acc = ACC_LOAD;
    endcase
    return req;
  endfunction

  task automatic issue_search(input tlb_search_req_t req);
    search_req   = req;
    search_valid = 1'b1;
    exp_q.push_back(ref_translate(req));
  endtask

  task automatic wait_room();
    int cnt;
    cnt = 0;
    while (!search_room) begin
      if (cnt >= 100) begin
        $display("timed out waiting for room in the result queue");
        fail_stop();
      end
      cnt++;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic search_one(input tlb_search_req_t req);
    wait_room();
    issue_search(req);
    @(posedge clk);
    #1;
    search_valid = 1'b0;
  endtask

  task automatic drain_results();
    int cnt;
    cnt          = 0;
    stall        = 1'b0;
    search_valid = 1'b0;
    while (exp_q.size() != 0) begin
      if (cnt >= 100) begin
        $display("timed out waiting for outstanding translation results");
        fail_stop();
      end
      cnt++;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_one(input int idx, input tlb_entry_t e);
    write_valid     = 1'b1;
    write_req.idx   = `TLB_IDX_W'(idx);
    write_req.entry = e;
    mirror[idx]     = e;
    @(posedge clk);
    #1;
    write_valid = 1'b0;
  endtask

  task automatic fill_all();
    for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
      write_one(i, rand_entry(i));
    end
  endtask

  task automatic read_check(input int idx);
    read_valid = 1'b1;
    read_idx   = `TLB_IDX_W'(idx);
    @(posedge clk);
    #1;
    read_valid = 1'b0;
    check_value(read_entry, mirror[idx], "tlbrd entry");
  endtask

  task automatic do_invalidate(input int op, input int k);
    logic asid_eq;
    logic sel;
    inv_req.op   = inv_op_e'(op);
    inv_req.asid = mirror[k].asid;
    inv_req.vppn = mirror[k].vppn;
    inv_valid    = 1'b1;
    for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
      asid_eq = (mirror[i].asid == inv_req.asid);
      case (op)
        2:       sel = mirror[i].glo;
        3:       sel = !mirror[i].glo;
        4:       sel = !mirror[i].glo && asid_eq;
        5:       sel = !mirror[i].glo && asid_eq && va_hits(mirror[i], {inv_req.vppn, 13'h0});
        6:       sel = (mirror[i].glo || asid_eq) && va_hits(mirror[i], {inv_req.vppn, 13'h0});
        default: sel = 1'b1;
      endcase
      if (sel) begin
        mirror[i].exist = 1'b0;
      end
    end
    @(posedge clk);
    #1;
    inv_valid = 1'b0;
  endtask

  // issue whenever room is high, stall toggled in random stretches
  task automatic run_searches(input int n, input bit use_stall);
    int          sent;
    int          idle;
    int          stall_left;
    logic [31:0] r;
    sent       = 0;
    idle       = 0;
    stall_left = 0;
    while (sent < n) begin
      r = $random(seed);
      if (use_stall && stall_left == 0) begin
        stall      = r[0];
        stall_left = 1 + int'(r[3:1]);
      end else if (use_stall) begin
        stall_left--;
      end
      if (search_room && r[4]) begin
        issue_search(rand_search());
        sent++;
        idle = 0;
      end else begin
        search_valid = 1'b0;
        idle++;
      end
      if (idle >= 200) begin
        $display("timed out issuing searches, room never came back");
        fail_stop();
      end
      @(posedge clk);
      #1;
    end
    search_valid = 1'b0;
    stall        = 1'b0;
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    int          issued;
    int          cnt;
    logic [31:0] r;
    seed         = 32'h99d3_df65;
    error_count  = 0;
    clk          = 1'b0;
    rst_n        = 1'b0;
    search_valid = 1'b0;
    search_req   = '0;
    stall        = 1'b0;
    read_valid   = 1'b0;
    read_idx     = '0;
    write_valid  = 1'b0;
    write_req    = '0;
    inv_valid    = 1'b0;
    inv_req      = '0;
    for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
      mirror[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value(search_room, 1'b1, "search_room after reset");

    // translations and exceptions over random entries
    fill_all();
    run_searches(60, 1'b0);
    drain_results();

    // tlbrd right after tlbwr
    for (int n = 0; n < 6; n++) begin
      r = $random(seed);
      write_one(int'(r[3:0]), rand_entry(int'(r[3:0])));
      read_check(int'(r[3:0]));
    end

    // every invtlb option, then reads and searches of each slot
    for (int op = 0; op < 7; op++) begin
      fill_all();
      r = $random(seed);
      do_invalidate(op, int'(r[3:0]));
      for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
        read_check(i);
      end
      for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
        search_one('{vaddr: {mirror[i].vppn, 13'h0}, asid: mirror[i].asid,
                     acc: ACC_LOAD, cur_plv: 2'd0});
      end
      drain_results();
    end

    // room drops with depth-1 queued and one more in flight
    fill_all();
    stall  = 1'b1;
    issued = 0;
    cnt    = 0;
    while (search_room) begin
      if (cnt >= 20) begin
        $display("search_room stayed high with the check stage stalled");
        fail_stop();
      end
      cnt++;
      issue_search(rand_search());
      issued++;
      @(posedge clk);
      #1;
    end
    search_valid = 1'b0;
    check_value(issued, `XQ_DEPTH, "searches accepted before room dropped");
    drain_results();

    run_searches(80, 1'b1);
    drain_results();

    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- mmu_xlate.f
+incdir+hw
hw/tlb_pkg.sv
hw/tlb_array.sv
hw/xlate_fifo.sv
hw/xlate_check.sv
hw/mmu_xlate_top.sv
verif/mmu_xlate_asserts.sv
verif/mmu_xlate_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the translation slice testbench with Verilator

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module mmu_xlate_tb -f mmu_xlate.f \
  -o mmu_xlate_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/mmu_xlate_sim > sim.log 2>&1
grep -q "Test FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation ended without a verdict, see sim.log"; exit 1; }
echo "simulation passed"
